//--- cache_defs.svh
// width macros shared by the packages and the cache RTL, pulled in with `include
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// processor side addresses 32-bit words
`define P_ADDR_W 25

// word address minus the 2 word-offset bits
`define LINE_ADDR_W 23

// kept small so the reset-cleared valid and lru state stays cheap
`define INDEX_W 4

`define TAG_W (`LINE_ADDR_W - `INDEX_W)

`define WORD_W 32

// one line is four words
`define LINE_W 128

`define WAYS 4

`endif

//--- bus_pkg.sv
// bus types for the processor request port and the memory command port of the cache
`default_nettype none

`include "cache_defs.svh"

package bus_pkg;

    // processor request, held stable while waitrequest is high
    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [`P_ADDR_W-1:0]      addr;
        logic [`WORD_W/8-1:0]      byte_en;
        logic [`WORD_W-1:0]        wdata;
    } proc_req_t;

    // memory command, addr is a line address
    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [`LINE_ADDR_W-1:0]   addr;
        logic [`LINE_W-1:0]        wline;
    } mem_cmd_t;

endpackage

`default_nettype wire

//--- cache_pkg.sv
// internal cache types for lines, tag entries, way vectors and lru orders
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

    // flat on the memory side, word array for the word select and byte merge
    typedef union packed {
        logic [`LINE_W-1:0]                      flat;
        logic [`LINE_W/`WORD_W-1:0][`WORD_W-1:0] words;
    } line_u;

    // one tag array entry
    typedef struct packed {
        logic              dirty;
        logic [`TAG_W-1:0] tag;
    } tag_entry_t;

    // one bit per way
    typedef logic [`WAYS-1:0] way_vec_t;

    typedef logic [$clog2(`WAYS)-1:0] way_num_t;

    // slot 0 least recent, top slot most recent
    typedef way_num_t [`WAYS-1:0] lru_order_t;

endpackage

`default_nettype wire

//--- cache_way.sv
// one cache way with data, tag and valid arrays, read one cycle after the index is presented
`default_nettype none

`include "cache_defs.svh"

module cache_way (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [`INDEX_W-1:0]           i_index,
    input  wire [`TAG_W-1:0]             i_tag,
    input  wire                          i_write,
    input  wire                          i_mark_dirty,
    input  wire [`LINE_W/`WORD_W-1:0]    i_word_en,
    input  wire [`WORD_W/8-1:0]          i_byte_en,
    input  wire cache_pkg::line_u        i_line,
    output cache_pkg::line_u             o_line,
    output logic                         o_hit,
    output logic                         o_valid,
    output logic                         o_dirty,
    output logic [`LINE_ADDR_W-1:0]      o_victim_addr
);

    cache_pkg::line_u      data_mem [2**`INDEX_W];
    cache_pkg::tag_entry_t tag_mem [2**`INDEX_W];
    logic [2**`INDEX_W-1:0] valid_r;
    cache_pkg::tag_entry_t tag_q;
    logic                  valid_q;

    // byte lanes of the selected words only
    always_ff @(posedge clk) begin
        for (int w = 0; w < `LINE_W/`WORD_W; w++) begin
            for (int b = 0; b < `WORD_W/8; b++) begin
                if (i_write && i_word_en[w] && i_byte_en[b]) begin
                    data_mem[i_index].words[w][8*b +: 8] <= i_line.words[w][8*b +: 8];
                end
            end
        end
        o_line <= data_mem[i_index];
    end

    // any write leaves the tag current, dirty comes from the controller
    always_ff @(posedge clk) begin
        if (i_write) begin
            tag_mem[i_index] <= '{dirty: i_mark_dirty, tag: i_tag};
        end
        tag_q <= tag_mem[i_index];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= '0;
            valid_q <= 1'b0;
        end else begin
            if (i_write) begin
                valid_r[i_index] <= 1'b1;
            end
            valid_q <= valid_r[i_index];
        end
    end

    assign o_hit   = valid_q && (tag_q.tag == i_tag);
    assign o_valid = valid_q;
    assign o_dirty = tag_q.dirty;

    // line address of the stored line, used for write-back
    assign o_victim_addr = {tag_q.tag, i_index};

endmodule

`default_nettype wire

//--- lru_order.sv
// per-set lru order with a touch update and a registered least-recent way output
`default_nettype none

`include "cache_defs.svh"

module lru_order (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`INDEX_W-1:0]      i_index,
    input  wire                     i_touch,
    input  wire cache_pkg::way_num_t i_touch_way,
    output cache_pkg::way_num_t     o_lru_way
);

    localparam cache_pkg::lru_order_t LRU_IDENT = {2'd3, 2'd2, 2'd1, 2'd0};

    cache_pkg::lru_order_t order_r [2**`INDEX_W];

    // pull the touched way out and append it as most recent
    function automatic cache_pkg::lru_order_t touch_order(
        input cache_pkg::lru_order_t cur,
        input cache_pkg::way_num_t   way
    );
        cache_pkg::lru_order_t nxt;
        logic                  found;
        found = 1'b0;
        for (int s = 0; s < `WAYS - 1; s++) begin
            if (cur[s] == way) begin
                found = 1'b1;
            end
            nxt[s] = found ? cur[s+1] : cur[s];
        end
        nxt[`WAYS-1] = way;
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**`INDEX_W; i++) begin
                order_r[i] <= LRU_IDENT;
            end
            o_lru_way <= '0;
        end else begin
            if (i_touch) begin
                order_r[i_index] <= touch_order(order_r[i_index], i_touch_way);
            end
            o_lru_way <= order_r[i_index][0];
        end
    end

endmodule

`default_nettype wire

//--- cache_ctrl.sv
// cache access FSM with hit handling, line fetch, dirty write-back and memory command registers
`default_nettype none

`include "cache_defs.svh"

module cache_ctrl (
    input  wire                               clk,
    input  wire                               rst,
    input  wire bus_pkg::proc_req_t           i_p_req,
    output logic [`WORD_W-1:0]                o_p_readdata,
    output logic                              o_p_readdata_valid,
    output logic                              o_p_waitrequest,
    output bus_pkg::mem_cmd_t                 o_m_cmd,
    input  wire cache_pkg::line_u             i_m_readdata,
    input  wire                               i_m_readdata_valid,
    input  wire                               i_m_waitrequest,
    output logic [`INDEX_W-1:0]               o_index,
    output logic [`TAG_W-1:0]                 o_tag,
    output cache_pkg::way_vec_t               o_way_write,
    output logic                              o_mark_dirty,
    output logic [`LINE_W/`WORD_W-1:0]        o_word_en,
    output logic [`WORD_W/8-1:0]              o_byte_en,
    output cache_pkg::line_u                  o_wr_line,
    input  wire cache_pkg::way_vec_t          i_hit,
    input  wire cache_pkg::way_vec_t          i_valid,
    input  wire cache_pkg::way_vec_t          i_dirty,
    input  wire cache_pkg::line_u [`WAYS-1:0] i_way_line,
    input  wire [`WAYS-1:0][`LINE_ADDR_W-1:0] i_victim_addr,
    input  wire cache_pkg::way_num_t          i_lru_way,
    output logic                              o_touch,
    output cache_pkg::way_num_t               o_touch_way
);

    typedef enum logic [2:0] {
        IDLE, COMP, HIT, FETCH_REQ, FETCH_WAIT, FILL_WRITE, WB_SETUP, WB_WAIT
    } state_t;

    state_t               state;
    bus_pkg::proc_req_t   req_q;
    cache_pkg::way_num_t  way_q;
    cache_pkg::way_num_t  hit_num;
    cache_pkg::way_num_t  victim_num;
    cache_pkg::way_vec_t  way_onehot;
    cache_pkg::line_u     hit_line;
    logic [`P_ADDR_W-1:0] addr_sel;
    logic [`LINE_ADDR_W-1:0] line_addr;
    logic [1:0]           word_off;
    logic                 victim_dirty;
    logic                 filling;

    // arrays see the live request only while idle
    assign addr_sel  = (state == IDLE) ? i_p_req.addr : req_q.addr;
    assign line_addr = addr_sel[`P_ADDR_W-1:2];
    assign o_index   = line_addr[`INDEX_W-1:0];
    assign o_tag     = line_addr[`LINE_ADDR_W-1:`INDEX_W];
    assign word_off  = req_q.addr[1:0];

    // lowest hitting way, and victim is first invalid way else lru way
    always_comb begin
        hit_num    = '0;
        victim_num = i_lru_way;
        for (int w = `WAYS - 1; w >= 0; w--) begin
            if (i_hit[w]) begin
                hit_num = cache_pkg::way_num_t'(w);
            end
            if (!i_valid[w]) begin
                victim_num = cache_pkg::way_num_t'(w);
            end
        end
    end

    assign hit_line     = i_way_line[hit_num];
    assign victim_dirty = i_valid[victim_num] && i_dirty[victim_num];
    assign way_onehot   = cache_pkg::way_vec_t'(1) << way_q;
    assign filling      = (state == FETCH_WAIT);

    // fill writes the whole memory line, otherwise one word with its byte enables
    assign o_word_en = filling ? '1 : (`LINE_W/`WORD_W)'(1) << word_off;
    assign o_byte_en = filling ? '1 : req_q.byte_en;

    always_comb begin
        if (filling) begin
            o_wr_line = i_m_readdata;
        end else begin
            o_wr_line.flat = {(`LINE_W/`WORD_W){req_q.wdata}};
        end
    end

    assign o_way_write  = (state == HIT || state == FILL_WRITE ||
                           (filling && i_m_readdata_valid)) ? way_onehot : '0;
    assign o_mark_dirty = (state == HIT) || (state == FILL_WRITE);

    // hits touch in COMP, misses touch when the line lands
    assign o_touch     = (state == COMP && |i_hit) || (filling && i_m_readdata_valid);
    assign o_touch_way = (state == COMP) ? hit_num : way_q;

    assign o_p_waitrequest = (state != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= IDLE;
            req_q              <= '0;
            way_q              <= '0;
            o_p_readdata_valid <= 1'b0;
            o_m_cmd.read       <= 1'b0;
            o_m_cmd.write      <= 1'b0;
        end else begin
            o_p_readdata_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_p_req.read || i_p_req.write) begin
                        req_q <= i_p_req;
                        state <= COMP;
                    end
                end
                COMP: begin
                    if (|i_hit) begin
                        way_q <= hit_num;
                        if (req_q.read) begin
                            o_p_readdata       <= hit_line.words[word_off];
                            o_p_readdata_valid <= 1'b1;
                            state              <= IDLE;
                        end else begin
                            state <= HIT;
                        end
                    end else begin
                        way_q <= victim_num;
                        if (victim_dirty) begin
                            state <= WB_SETUP;
                        end else begin
                            o_m_cmd.read <= 1'b1;
                            o_m_cmd.addr <= req_q.addr[`P_ADDR_W-1:2];
                            state        <= FETCH_REQ;
                        end
                    end
                end
                HIT: begin
                    state <= IDLE;
                end
                FETCH_REQ: begin
                    if (!i_m_waitrequest) begin
                        o_m_cmd.read <= 1'b0;
                        state        <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (i_m_readdata_valid) begin
                        if (req_q.write) begin
                            state <= FILL_WRITE;
                        end else begin
                            o_p_readdata       <= i_m_readdata.words[word_off];
                            o_p_readdata_valid <= 1'b1;
                            state              <= IDLE;
                        end
                    end
                end
                // pending write lands on top of the fresh line
                FILL_WRITE: begin
                    state <= IDLE;
                end
                WB_SETUP: begin
                    o_m_cmd.addr  <= i_victim_addr[way_q];
                    o_m_cmd.wline <= i_way_line[way_q].flat;
                    o_m_cmd.write <= 1'b1;
                    state         <= WB_WAIT;
                end
                WB_WAIT: begin
                    if (!i_m_waitrequest) begin
                        o_m_cmd.write <= 1'b0;
                        o_m_cmd.read  <= 1'b1;
                        o_m_cmd.addr  <= req_q.addr[`P_ADDR_W-1:2];
                        state         <= FETCH_REQ;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- cache_top.sv
// top level of the four-way write-back cache, connects the ways, the lru and the controller
`default_nettype none

`include "cache_defs.svh"

module cache_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire bus_pkg::proc_req_t  i_p_req,
    output logic [`WORD_W-1:0]       o_p_readdata,
    output logic                     o_p_readdata_valid,
    output logic                     o_p_waitrequest,
    output bus_pkg::mem_cmd_t        o_m_cmd,
    input  wire cache_pkg::line_u    i_m_readdata,
    input  wire                      i_m_readdata_valid,
    input  wire                      i_m_waitrequest
);

    cache_pkg::line_u [`WAYS-1:0]      way_line;
    logic [`WAYS-1:0][`LINE_ADDR_W-1:0] victim_addr;
    cache_pkg::way_vec_t               way_hit;
    cache_pkg::way_vec_t               way_valid;
    cache_pkg::way_vec_t               way_dirty;
    cache_pkg::way_vec_t               way_write;
    cache_pkg::line_u                  wr_line;
    cache_pkg::way_num_t               lru_way;
    cache_pkg::way_num_t               touch_way;
    logic [`INDEX_W-1:0]               index;
    logic [`TAG_W-1:0]                 tag;
    logic [`LINE_W/`WORD_W-1:0]        word_en;
    logic [`WORD_W/8-1:0]              byte_en;
    logic                              mark_dirty;
    logic                              touch;

    // all ways share index, tag and write data, each has its own strobe
    for (genvar g = 0; g < `WAYS; g++) begin : g_way
        cache_way u_way (
            .clk           (clk),
            .rst           (rst),
            .i_index       (index),
            .i_tag         (tag),
            .i_write       (way_write[g]),
            .i_mark_dirty  (mark_dirty),
            .i_word_en     (word_en),
            .i_byte_en     (byte_en),
            .i_line        (wr_line),
            .o_line        (way_line[g]),
            .o_hit         (way_hit[g]),
            .o_valid       (way_valid[g]),
            .o_dirty       (way_dirty[g]),
            .o_victim_addr (victim_addr[g])
        );
    end

    lru_order u_lru (
        .clk         (clk),
        .rst         (rst),
        .i_index     (index),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .o_lru_way   (lru_way)
    );

    cache_ctrl u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .i_p_req            (i_p_req),
        .o_p_readdata       (o_p_readdata),
        .o_p_readdata_valid (o_p_readdata_valid),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_m_cmd            (o_m_cmd),
        .i_m_readdata       (i_m_readdata),
        .i_m_readdata_valid (i_m_readdata_valid),
        .i_m_waitrequest    (i_m_waitrequest),
        .o_index            (index),
        .o_tag              (tag),
        .o_way_write        (way_write),
        .o_mark_dirty       (mark_dirty),
        .o_word_en          (word_en),
        .o_byte_en          (byte_en),
        .o_wr_line          (wr_line),
        .i_hit              (way_hit),
        .i_valid            (way_valid),
        .i_dirty            (way_dirty),
        .i_way_line         (way_line),
        .i_victim_addr      (victim_addr),
        .i_lru_way          (lru_way),
        .o_touch            (touch),
        .o_touch_way        (touch_way)
    );

endmodule

`default_nettype wire

//--- tb_cache.sv
// testbench for the four-way cache, replays the pattern file twice, the second time under memory back-pressure
`default_nettype none

`include "cache_defs.svh"

module tb_cache;

    localparam int PAT_MAX = 64;
    localparam int TIMEOUT = 400;
    localparam logic [3:0] OP_READ   = 4'h1;
    localparam logic [3:0] OP_WRITE  = 4'h2;
    localparam logic [3:0] EXP_HIT   = 4'h0;
    localparam logic [3:0] EXP_WB    = 4'h2;

    // one pattern line, nibble aligned with the hex columns of the file
    typedef struct packed {
        logic [3:0]  op;
        logic [3:0]  traffic;
        logic [27:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic [23:0] wb_addr;
    } pattern_t;

    logic                    clk;
    logic                    rst;
    bus_pkg::proc_req_t      p_req;
    logic [`WORD_W-1:0]      p_readdata;
    logic                    p_readdata_valid;
    logic                    p_waitrequest;
    bus_pkg::mem_cmd_t       m_cmd;
    cache_pkg::line_u        m_rdata;
    logic                    m_valid;
    logic                    m_wait;

    logic [95:0]             pat_raw [PAT_MAX];
    logic [31:0]             lfsr = 32'h05f1aaa9;
    logic                    bp_on;
    cache_pkg::line_u        mem_lines [logic [`LINE_ADDR_W-1:0]];
    cache_pkg::line_u        ref_lines [logic [`LINE_ADDR_W-1:0]];
    int                      rd_count;
    int                      wb_count;
    logic [`LINE_ADDR_W-1:0] rd_addr_seen;
    logic [`LINE_ADDR_W-1:0] wb_addr_seen;
    cache_pkg::line_u        wb_line_seen;

    cache_top dut0 (
        .clk                (clk),
        .rst                (rst),
        .i_p_req            (p_req),
        .o_p_readdata       (p_readdata),
        .o_p_readdata_valid (p_readdata_valid),
        .o_p_waitrequest    (p_waitrequest),
        .o_m_cmd            (m_cmd),
        .i_m_readdata       (m_rdata),
        .i_m_readdata_valid (m_valid),
        .i_m_waitrequest    (m_wait)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    // unwritten memory, every word scrambled from its full word address
    function automatic cache_pkg::line_u default_line(input logic [`LINE_ADDR_W-1:0] la);
        cache_pkg::line_u l;
        for (int w = 0; w < `LINE_W/`WORD_W; w++) begin
            l.words[w] = (32'({la, 2'(w)}) * 32'h9e3779b1) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    function automatic cache_pkg::line_u mem_line(input logic [`LINE_ADDR_W-1:0] la);
        return mem_lines.exists(la) ? mem_lines[la] : default_line(la);
    endfunction

    function automatic cache_pkg::line_u ref_line(input logic [`LINE_ADDR_W-1:0] la);
        return ref_lines.exists(la) ? ref_lines[la] : default_line(la);
    endfunction

    // what the processor expects memory to hold after a byte-enabled write
    function automatic void merge_ref(input logic [`P_ADDR_W-1:0] addr, input logic [3:0] be,
                                      input logic [`WORD_W-1:0] wdata);
        cache_pkg::line_u merged;
        merged = ref_line(addr[`P_ADDR_W-1:2]);
        for (int b = 0; b < `WORD_W/8; b++) begin
            if (be[b]) begin
                merged.words[addr[1:0]][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        ref_lines[addr[`P_ADDR_W-1:2]] = merged;
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string why);
        $display("[ERROR] %s", why);
        abort_run();
    endtask

    task automatic check_word(input string name, input logic [`WORD_W-1:0] got,
                              input logic [`WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(input string name, input cache_pkg::line_u got,
                              input cache_pkg::line_u exp);
        if (got.flat !== exp.flat) begin
            $display("[FAIL] %s got %h expected %h", name, got.flat, exp.flat);
            abort_run();
        end
    endtask

    task automatic check_line_addr(input string name, input logic [`LINE_ADDR_W-1:0] got,
                                   input logic [`LINE_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // memory with random back-pressure and a variable read latency
    initial begin : memory_model
        logic                    pending;
        int                      countdown;
        logic [`LINE_ADDR_W-1:0] pend_addr;
        cache_pkg::line_u        wline;
        m_rdata   = '0;
        m_valid   = 1'b0;
        m_wait    = 1'b0;
        rd_count  = 0;
        wb_count  = 0;
        pending   = 1'b0;
        countdown = 0;
        pend_addr = '0;
        forever begin
            // a command seen here with waitrequest low is taken on the next edge
            @(negedge clk);
            if (rst) begin
                pending = 1'b0;
            end else if (!m_wait) begin
                if (m_cmd.write) begin
                    wline.flat = m_cmd.wline;
                    mem_lines[m_cmd.addr] = wline;
                    wb_count++;
                    wb_addr_seen = m_cmd.addr;
                    wb_line_seen = wline;
                end
                if (m_cmd.read) begin
                    rd_count++;
                    rd_addr_seen = m_cmd.addr;
                    pend_addr = m_cmd.addr;
                    pending = 1'b1;
                    countdown = 0;
                    if (bp_on) begin
                        countdown = take_bits(2);
                    end
                end
            end
            @(posedge clk);
            #10;
            m_valid = 1'b0;
            if (pending) begin
                if (countdown == 0) begin
                    m_rdata = mem_line(pend_addr);
                    m_valid = 1'b1;
                    pending = 1'b0;
                end else begin
                    countdown--;
                end
            end
            m_wait = 1'b0;
            if (bp_on) begin
                m_wait = lfsr_bit();
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        #10;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        if (p_readdata_valid || p_waitrequest || m_cmd.read || m_cmd.write) begin
            report_error("cache outputs are not idle after reset");
        end
    endtask

    // memory commands of one access against the expected traffic class
    task automatic check_traffic(input pattern_t pat, input logic [`LINE_ADDR_W-1:0] la);
        int exp_rd;
        int exp_wb;
        exp_rd = (pat.traffic == EXP_HIT) ? 0 : 1;
        exp_wb = (pat.traffic == EXP_WB) ? 1 : 0;
        if (rd_count != exp_rd || wb_count != exp_wb) begin
            report_error($sformatf("access to %h wanted %0d reads and %0d writes, saw %0d and %0d",
                                   pat.addr, exp_rd, exp_wb, rd_count, wb_count));
        end
        if (exp_rd == 1) begin
            check_line_addr("o_m_cmd.addr (read)", rd_addr_seen, la);
        end
        if (exp_wb == 1) begin
            check_line_addr("o_m_cmd.addr (write)", wb_addr_seen,
                            pat.wb_addr[`LINE_ADDR_W-1:0]);
            check_line("o_m_cmd.wline", wb_line_seen, ref_line(pat.wb_addr[`LINE_ADDR_W-1:0]));
        end
    endtask

    task automatic run_pattern(input pattern_t pat);
        logic [`LINE_ADDR_W-1:0] la;
        cache_pkg::line_u        exp_line;
        int                      waits;
        int                      edges;
        la = pat.addr[`P_ADDR_W-1:2];
        rd_count = 0;
        wb_count = 0;
        @(posedge clk);
        #10;
        p_req.read    = (pat.op == OP_READ);
        p_req.write   = (pat.op == OP_WRITE);
        p_req.addr    = pat.addr[`P_ADDR_W-1:0];
        p_req.byte_en = pat.be;
        p_req.wdata   = pat.wdata;
        waits = 0;
        @(negedge clk);
        while (p_waitrequest) begin
            waits++;
            if (waits > TIMEOUT) begin
                report_error("request was never accepted");
            end
            @(negedge clk);
        end
        // acceptance edge counts as edge 1
        @(posedge clk);
        #10;
        p_req = '0;
        edges = 1;
        @(negedge clk);
        if (pat.op == OP_READ) begin
            while (!p_readdata_valid) begin
                if (edges > TIMEOUT) begin
                    report_error("read data never came back");
                end
                @(posedge clk);
                edges++;
                @(negedge clk);
            end
            exp_line = ref_line(la);
            check_word("o_p_readdata", p_readdata, exp_line.words[pat.addr[1:0]]);
            if (pat.traffic == EXP_HIT && edges != 2) begin
                report_error($sformatf("read hit data came %0d edges after acceptance", edges));
            end
            if (pat.traffic == EXP_HIT && p_waitrequest) begin
                report_error("read hit kept waitrequest high for more than one cycle");
            end
            @(posedge clk);
            @(negedge clk);
            if (p_readdata_valid) begin
                report_error("read data valid stayed high for more than one cycle");
            end
            check_traffic(pat, la);
        end else begin
            waits = 0;
            while (p_waitrequest) begin
                waits++;
                if (waits > TIMEOUT) begin
                    report_error("write never completed");
                end
                @(negedge clk);
            end
            if (pat.traffic == EXP_HIT && waits != 2) begin
                report_error($sformatf("write hit kept waitrequest high for %0d cycles", waits));
            end
            check_traffic(pat, la);
            merge_ref(pat.addr[`P_ADDR_W-1:0], pat.be, pat.wdata);
        end
    endtask

    initial begin : stimulus
        int n_pat;
        rst   = 1'b1;
        p_req = '0;
        bp_on = 1'b0;
        for (int i = 0; i < PAT_MAX; i++) begin
            pat_raw[i] = '0;
        end
        $readmemh("cache_patterns.txt", pat_raw);
        n_pat = 0;
        while (n_pat < PAT_MAX && pat_raw[n_pat][95:92] != 4'h0) begin
            n_pat++;
        end
        if (n_pat == 0) begin
            report_error("no patterns were read from the pattern file");
        end
        // second pass starts from reset with fresh memory, results must match
        for (int pass = 0; pass < 2; pass++) begin
            bp_on = (pass == 1);
            mem_lines.delete();
            ref_lines.delete();
            apply_reset();
            for (int i = 0; i < n_pat; i++) begin
                run_pattern(pattern_t'(pat_raw[i]));
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_patterns.txt
// op (1 read, 2 write), traffic (0 none, 1 fetch, 2 write-back then fetch),
// word address, byte enable, write data, expected write-back line address
// set 1, read miss then hits and partial writes
1_1_0000004_0_00000000_000000
1_0_0000006_0_00000000_000000
2_0_0000006_3_aabbccdd_000000
2_0_0000006_8_11223344_000000
1_0_0000006_0_00000000_000000
1_0_0000005_0_00000000_000000
// set 4, write miss fetches the line and merges the word
2_1_0000213_6_cafef00d_000000
1_0_0000213_0_00000000_000000
// set 5, tags 1 to 4 fill the four ways, tag 2 dirty
1_1_0000054_0_00000000_000000
2_1_0000095_f_12345678_000000
1_1_00000d6_0_00000000_000000
1_1_0000117_0_00000000_000000
// touch order leaves tag 2 least recent
2_0_0000094_5_a5a5a5a5_000000
1_0_0000055_0_00000000_000000
1_0_00000d4_0_00000000_000000
1_0_0000114_0_00000000_000000
// tag 5 evicts dirty tag 2, then tag 2 evicts clean tag 1
1_2_0000156_0_00000000_000025
2_1_0000096_c_deadbeef_000000
1_0_0000095_0_00000000_000000
1_0_0000094_0_00000000_000000
1_0_0000096_0_00000000_000000
// tag 1 is gone, clean tag 3 makes room
1_1_0000054_0_00000000_000000

//--- compile.f
+incdir+.
bus_pkg.sv
cache_pkg.sv
cache_way.sv
lru_order.sv
cache_ctrl.sv
cache_top.sv
tb_cache.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module tb_cache
	verilator --lint-only -I. bus_pkg.sv cache_pkg.sv cache_way.sv lru_order.sv \
		cache_ctrl.sv cache_top.sv --top-module cache_top

sim:
	verilator --binary --timing -f compile.f --top-module tb_cache -o tb_cache_sim
	./obj_dir/tb_cache_sim > sim.log 2>&1; cat sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
